// File: Makefile
# Verilator flow for the vector datapath testbench

VERILATOR ?= verilator
TOP       ?= mlacc_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
CREDITS   ?= 4
VFLAGS    ?= --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) -Gresult_credits=$(CREDITS) \
		--top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
source/mlacc_pkg.sv
source/mlacc_decode.sv
source/fixedp_mul.sv
source/mlacc_execute.sv
source/fixedp_add.sv
source/mlacc_result.sv
source/mlacc_datapath.sv
verification/mlacc_tb.sv

// File: source/fixedp_add.sv
`timescale 1ns/1ns
`default_nettype none

module fixedp_add (
    input  wire mlacc_pkg::word_t a,
    input  wire mlacc_pkg::word_t b,
    output mlacc_pkg::word_t      s
);
    import mlacc_pkg::*;

    localparam int mag_len = word_len - 1;

    logic               sign_a;
    logic               sign_b;
    logic [mag_len-1:0] mag_a;
    logic [mag_len-1:0] mag_b;
    logic [mag_len-1:0] mag_s;
    logic               sign_s;

    assign sign_a = a[word_len-1];
    assign sign_b = b[word_len-1];
    assign mag_a  = a[mag_len-1:0];
    assign mag_b  = b[mag_len-1:0];

    always_comb begin
        if (sign_a == sign_b) begin
            // same sign, magnitude wraps modulo 2^31
            mag_s  = mag_a + mag_b;
            sign_s = sign_a;
        end else if (mag_a >= mag_b) begin
            mag_s  = mag_a - mag_b;
            sign_s = sign_a;
        end else begin
            mag_s  = mag_b - mag_a;
            sign_s = sign_b;
        end
    end

    // no negative zero
    assign s = {sign_s && (mag_s != '0), mag_s};

endmodule

`default_nettype wire

// File: source/fixedp_mul.sv
`timescale 1ns/1ns
`default_nettype none

module fixedp_mul (
    input  wire mlacc_pkg::word_t a,
    input  wire mlacc_pkg::word_t b,
    output mlacc_pkg::word_t      c
);
    import mlacc_pkg::*;

    localparam int mag_len = word_len - 1;

    logic [mag_len-1:0]   mag_a;
    logic [mag_len-1:0]   mag_b;
    logic [2*mag_len-1:0] product;
    logic [mag_len-1:0]   mag_c;
    logic                 sign_c;

    assign mag_a = a[mag_len-1:0];
    assign mag_b = b[mag_len-1:0];

    // full 62-bit product of the magnitudes
    assign product = mag_a * mag_b;

    // drop the extra fraction bits, keep the low 31 bits above them
    assign mag_c = product[frac_len +: mag_len];

    // zero always comes out positive
    assign sign_c = (a[word_len-1] ^ b[word_len-1]) && (mag_c != '0);

    assign c = {sign_c, mag_c};

endmodule

`default_nettype wire

// File: source/mlacc_datapath.sv
`timescale 1ns/1ns
`default_nettype none

module mlacc_datapath #(
    parameter int result_credits = 4
) (
    input  wire logic                  in_clk,
    input  wire logic                  arst_n,
    input  wire logic                  valid,
    input  wire mlacc_pkg::op_t        op,
    input  wire mlacc_pkg::lane_mask_t mask,
    input  wire mlacc_pkg::vec_t       x,
    input  wire mlacc_pkg::vec_t       y,
    input  wire mlacc_pkg::row_addr_t  row,
    input  wire mlacc_pkg::word_sel_t  word,
    input  wire logic                  first,
    input  wire logic                  credit_return,
    output logic                       ready,
    output logic                       result_valid,
    output mlacc_pkg::vec_t            z
);
    import mlacc_pkg::*;

    // decode to execute
    logic      dec_valid;
    op_t       dec_op;
    vec_t      dec_x;
    vec_t      dec_y;
    row_addr_t dec_row;
    word_sel_t dec_word;
    logic      dec_first;

    // execute to result
    logic      exe_valid;
    op_t       exe_op;
    vec_t      exe_a;
    vec_t      exe_b;
    row_addr_t exe_row;
    word_sel_t exe_word;
    logic      exe_first;

    mlacc_decode #(
        .result_credits (result_credits)
    ) u_decode (
        .in_clk        (in_clk),
        .arst_n        (arst_n),
        .valid         (valid),
        .op            (op),
        .mask          (mask),
        .x             (x),
        .y             (y),
        .row           (row),
        .word          (word),
        .first         (first),
        .credit_return (credit_return),
        .ready         (ready),
        .dec_valid     (dec_valid),
        .dec_op        (dec_op),
        .dec_x         (dec_x),
        .dec_y         (dec_y),
        .dec_row       (dec_row),
        .dec_word      (dec_word),
        .dec_first     (dec_first)
    );

    mlacc_execute u_execute (
        .in_clk    (in_clk),
        .arst_n    (arst_n),
        .dec_valid (dec_valid),
        .dec_op    (dec_op),
        .dec_x     (dec_x),
        .dec_y     (dec_y),
        .dec_row   (dec_row),
        .dec_word  (dec_word),
        .dec_first (dec_first),
        .exe_valid (exe_valid),
        .exe_op    (exe_op),
        .exe_a     (exe_a),
        .exe_b     (exe_b),
        .exe_row   (exe_row),
        .exe_word  (exe_word),
        .exe_first (exe_first)
    );

    mlacc_result u_result (
        .in_clk       (in_clk),
        .arst_n       (arst_n),
        .exe_valid    (exe_valid),
        .exe_op       (exe_op),
        .exe_a        (exe_a),
        .exe_b        (exe_b),
        .exe_row      (exe_row),
        .exe_word     (exe_word),
        .exe_first    (exe_first),
        .result_valid (result_valid),
        .z            (z)
    );

endmodule

`default_nettype wire

// File: source/mlacc_decode.sv
`timescale 1ns/1ns
`default_nettype none

module mlacc_decode #(
    parameter int result_credits = 4
) (
    input  wire logic                  in_clk,
    input  wire logic                  arst_n,
    input  wire logic                  valid,
    input  wire mlacc_pkg::op_t        op,
    input  wire mlacc_pkg::lane_mask_t mask,
    input  wire mlacc_pkg::vec_t       x,
    input  wire mlacc_pkg::vec_t       y,
    input  wire mlacc_pkg::row_addr_t  row,
    input  wire mlacc_pkg::word_sel_t  word,
    input  wire logic                  first,
    input  wire logic                  credit_return,
    output logic                       ready,
    output logic                       dec_valid,
    output mlacc_pkg::op_t             dec_op,
    output mlacc_pkg::vec_t            dec_x,
    output mlacc_pkg::vec_t            dec_y,
    output mlacc_pkg::row_addr_t       dec_row,
    output mlacc_pkg::word_sel_t       dec_word,
    output logic                       dec_first
);
    import mlacc_pkg::*;

    // enough for up to 15 credits
    localparam int credit_bits = 4;

    logic [credit_bits-1:0] credits;
    logic                   accept;
    vec_t                   x_masked;
    vec_t                   y_masked;

    assign ready  = (credits != '0);
    assign accept = valid && ready;

    // one credit per accepted operation, one back per return pulse
    always_ff @(posedge in_clk or negedge arst_n) begin
        if (!arst_n) begin
            credits <= credit_bits'(result_credits);
        end else if (accept && !credit_return) begin
            credits <= credits - 1'b1;
        end else if (!accept && credit_return) begin
            credits <= credits + 1'b1;
        end
    end

    // inactive lanes enter the pipeline as zero
    always_comb begin
        for (int p = 0; p < num_lanes; p++) begin
            x_masked[p*word_len +: word_len] = mask[p] ? x[p*word_len +: word_len] : '0;
            y_masked[p*word_len +: word_len] = mask[p] ? y[p*word_len +: word_len] : '0;
        end
    end

    always_ff @(posedge in_clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
            dec_op    <= op_nop;
        end else begin
            dec_valid <= accept;
            // a cycle without acceptance becomes a bubble
            dec_op    <= accept ? op : op_nop;
        end
    end

    always_ff @(posedge in_clk) begin
        if (accept) begin
            dec_x     <= x_masked;
            dec_y     <= y_masked;
            dec_row   <= row;
            dec_word  <= word;
            dec_first <= first;
        end
    end

endmodule

`default_nettype wire

// File: source/mlacc_execute.sv
`timescale 1ns/1ns
`default_nettype none

module mlacc_execute (
    input  wire logic                 in_clk,
    input  wire logic                 arst_n,
    input  wire logic                 dec_valid,
    input  wire mlacc_pkg::op_t       dec_op,
    input  wire mlacc_pkg::vec_t      dec_x,
    input  wire mlacc_pkg::vec_t      dec_y,
    input  wire mlacc_pkg::row_addr_t dec_row,
    input  wire mlacc_pkg::word_sel_t dec_word,
    input  wire logic                 dec_first,
    output logic                      exe_valid,
    output mlacc_pkg::op_t            exe_op,
    output mlacc_pkg::vec_t           exe_a,
    output mlacc_pkg::vec_t           exe_b,
    output mlacc_pkg::row_addr_t      exe_row,
    output mlacc_pkg::word_sel_t      exe_word,
    output logic                      exe_first
);
    import mlacc_pkg::*;

    vec_t products;
    vec_t y_neg;
    vec_t a_next;
    vec_t b_next;

    genvar p;
    generate
        for (p = 0; p < num_lanes; p++) begin : g_mul
            fixedp_mul u_mul (
                .a (dec_x[p*word_len +: word_len]),
                .b (dec_y[p*word_len +: word_len]),
                .c (products[p*word_len +: word_len])
            );
        end
    endgenerate

    // subtraction is an add with the sign of y flipped
    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            y_neg[i*word_len +: word_len] = {~dec_y[i*word_len + word_len - 1],
                                             dec_y[i*word_len +: word_len - 1]};
        end
    end

    always_comb begin
        case (dec_op)
            op_vmul, op_mvmul: begin
                a_next = products;
                b_next = '0;
            end
            op_vsub, op_vsgt: begin
                a_next = dec_x;
                b_next = y_neg;
            end
            default: begin
                a_next = dec_x;
                b_next = dec_y;
            end
        endcase
    end

    always_ff @(posedge in_clk or negedge arst_n) begin
        if (!arst_n) begin
            exe_valid <= 1'b0;
            exe_op    <= op_nop;
        end else begin
            exe_valid <= dec_valid;
            exe_op    <= dec_op;
        end
    end

    always_ff @(posedge in_clk) begin
        exe_a     <= a_next;
        exe_b     <= b_next;
        exe_row   <= dec_row;
        exe_word  <= dec_word;
        exe_first <= dec_first;
    end

endmodule

`default_nettype wire

// File: source/mlacc_pkg.sv
`default_nettype none

package mlacc_pkg;

    // sign-magnitude word: one sign bit, 31-bit magnitude, 15 of it fraction
    localparam int word_len = 32;
    localparam int frac_len = 15;

    // vector and scratchpad geometry
    localparam int num_lanes = 4;
    localparam int spad_addr_bits = 4;

    typedef logic [word_len-1:0] word_t;

    // lane 0 sits in the most significant word
    typedef logic [num_lanes*word_len-1:0] vec_t;

    // one active flag per lane, bit 3 is lane 0
    typedef logic [num_lanes-1:0] lane_mask_t;

    typedef logic [spad_addr_bits-1:0] row_addr_t;

    // lane of a scratchpad row that takes the dot product
    typedef logic [$clog2(num_lanes)-1:0] word_sel_t;

    typedef enum logic [2:0] {
        op_nop,
        op_vadd,
        op_vsub,
        op_vmul,
        // x > y per lane gives 1.0, else 0
        op_vsgt,
        // matrix-vector multiply, one row block per operation
        op_mvmul
    } op_t;

    // 1.0 in the fixed-point format
    localparam word_t fixed_one = 32'h0000_8000;

endpackage

`default_nettype wire

// File: source/mlacc_result.sv
`timescale 1ns/1ns
`default_nettype none

module mlacc_result (
    input  wire logic                 in_clk,
    input  wire logic                 arst_n,
    input  wire logic                 exe_valid,
    input  wire mlacc_pkg::op_t       exe_op,
    input  wire mlacc_pkg::vec_t      exe_a,
    input  wire mlacc_pkg::vec_t      exe_b,
    input  wire mlacc_pkg::row_addr_t exe_row,
    input  wire mlacc_pkg::word_sel_t exe_word,
    input  wire logic                 exe_first,
    output logic                      result_valid,
    output mlacc_pkg::vec_t           z
);
    import mlacc_pkg::*;

    localparam int spad_rows = 1 << spad_addr_bits;

    vec_t  spad [spad_rows];
    vec_t  row_rd;
    word_t psum;
    word_t add_b [num_lanes];
    word_t lane_sum [num_lanes];
    word_t sum02;
    word_t sum13;
    word_t dot;
    vec_t  sum_row;
    vec_t  sgt_row;
    vec_t  new_row;
    vec_t  z_next;
    logic  spad_we;

    // combinational read, so a write at this edge is seen by the next op
    assign row_rd = spad[exe_row];

    assign psum = exe_first ? '0
                            : row_rd[word_len*(num_lanes-1-int'(exe_word)) +: word_len];

    genvar l;
    generate
        for (l = 0; l < num_lanes; l++) begin : g_lane
            // the partial sum enters on lane 0, whose b operand is zero for mvmul
            if (l == 0) begin : g_psum
                assign add_b[l] = (exe_op == op_mvmul) ? psum
                                  : exe_b[(num_lanes-1-l)*word_len +: word_len];
            end else begin : g_plain
                assign add_b[l] = exe_b[(num_lanes-1-l)*word_len +: word_len];
            end

            fixedp_add u_add (
                .a (exe_a[(num_lanes-1-l)*word_len +: word_len]),
                .b (add_b[l]),
                .s (lane_sum[l])
            );
        end
    endgenerate

    // dot-product tree
    fixedp_add u_tree02 (.a(lane_sum[0]), .b(lane_sum[2]), .s(sum02));
    fixedp_add u_tree13 (.a(lane_sum[1]), .b(lane_sum[3]), .s(sum13));
    fixedp_add u_tree_all (.a(sum02), .b(sum13), .s(dot));

    always_comb begin
        for (int p = 0; p < num_lanes; p++) begin
            sum_row[p*word_len +: word_len] = lane_sum[num_lanes-1-p];

            // strictly positive difference means x > y
            if (!lane_sum[num_lanes-1-p][word_len-1]
                    && (lane_sum[num_lanes-1-p][word_len-2:0] != '0)) begin
                sgt_row[p*word_len +: word_len] = fixed_one;
            end else begin
                sgt_row[p*word_len +: word_len] = '0;
            end

            // selected word takes the new sum, a first block clears the rest
            if (exe_word == word_sel_t'(num_lanes-1-p)) begin
                new_row[p*word_len +: word_len] = dot;
            end else if (exe_first) begin
                new_row[p*word_len +: word_len] = '0;
            end else begin
                new_row[p*word_len +: word_len] = row_rd[p*word_len +: word_len];
            end
        end
    end

    always_comb begin
        case (exe_op)
            op_vadd, op_vsub: z_next = sum_row;
            op_vsgt:          z_next = sgt_row;
            op_vmul:          z_next = exe_a;
            op_mvmul:         z_next = new_row;
            default:          z_next = '0;
        endcase
    end

    assign spad_we = exe_valid && (exe_op == op_mvmul);

    always_ff @(posedge in_clk) begin
        if (spad_we) begin
            spad[exe_row] <= new_row;
        end
    end

    always_ff @(posedge in_clk or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= exe_valid;
        end
    end

    always_ff @(posedge in_clk) begin
        z <= z_next;
    end

endmodule

`default_nettype wire

// File: verification/mlacc_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mlacc_tb #(
    parameter int result_credits = 4
);
    import mlacc_pkg::*;

    localparam int wait_limit = 200;
    localparam word_t one_fx = word_t'(1) << frac_len;

    logic       in_clk = 1'b0;
    logic       arst_n;
    logic       valid;
    op_t        op;
    lane_mask_t mask;
    vec_t       x;
    vec_t       y;
    row_addr_t  row;
    word_sel_t  word;
    logic       first;
    logic       credit_return = 1'b0;
    logic       ready;
    logic       result_valid;
    vec_t       z;

    // reference scratchpad and the expected results in issue order
    vec_t       spad_m [16];
    vec_t       exp_z [$];
    op_t        exp_op [$];
    lane_mask_t exp_mask [$];
    int         exp_cyc [$];

    int    cyc = 0;
    int    acc_cnt = 0;
    int    results_seen = 0;
    int    credits_sent = 0;
    logic  returns_on = 1'b0;
    int    return_pct = 100;
    string test_name = "reset";
    int    err_data = 0;
    int    err_proto = 0;
    int    err_timeout = 0;

    mlacc_datapath #(.result_credits(result_credits)) uut (.*);

    always #2 in_clk = ~in_clk;

    always @(posedge in_clk) cyc <= cyc + 1;

    function automatic word_t lane_get(vec_t v, int l);
        return v[(num_lanes-1-l)*word_len +: word_len];
    endfunction

    function automatic vec_t lane_put(vec_t v, int l, word_t w);
        vec_t r;
        r = v;
        r[(num_lanes-1-l)*word_len +: word_len] = w;
        return r;
    endfunction

    // sign-magnitude sum, magnitude wraps at 2^31
    function automatic word_t ref_add(word_t a, word_t b);
        logic [30:0] ma;
        logic [30:0] mb;
        logic [30:0] ms;
        logic        sg;
        ma = a[30:0];
        mb = b[30:0];
        if (a[31] == b[31]) begin
            ms = ma + mb;
            sg = a[31];
        end else if (ma > mb) begin
            ms = ma - mb;
            sg = a[31];
        end else begin
            ms = mb - ma;
            sg = b[31];
        end
        return {sg && (ms != 31'd0), ms};
    endfunction

    function automatic word_t ref_mul(word_t a, word_t b);
        logic [61:0] p;
        logic [30:0] m;
        p = {31'd0, a[30:0]} * {31'd0, b[30:0]};
        m = p[45:15];
        return {(a[31] ^ b[31]) && (m != 31'd0), m};
    endfunction

    task automatic model_op(input op_t o, input lane_mask_t m, input vec_t xv, input vec_t yv,
                            input row_addr_t r, input word_sel_t w, input logic f,
                            output vec_t zv);
        word_t xl;
        word_t yl;
        word_t d;
        word_t prod [num_lanes];
        word_t total;
        word_t psum;
        vec_t  nrow;
        zv = '0;
        for (int l = 0; l < num_lanes; l++) begin
            // mask bit 3 belongs to lane 0
            xl = m[num_lanes-1-l] ? lane_get(xv, l) : '0;
            yl = m[num_lanes-1-l] ? lane_get(yv, l) : '0;
            prod[l] = ref_mul(xl, yl);
            d = ref_add(xl, {~yl[31], yl[30:0]});
            case (o)
                op_vadd: zv = lane_put(zv, l, ref_add(xl, yl));
                op_vsub: zv = lane_put(zv, l, d);
                op_vmul: zv = lane_put(zv, l, prod[l]);
                op_vsgt: zv = lane_put(zv, l, (!d[31] && d[30:0] != '0) ? one_fx : '0);
                default: ;
            endcase
        end
        if (o == op_mvmul) begin
            total = ref_add(ref_add(prod[0], prod[2]), ref_add(prod[1], prod[3]));
            psum = f ? '0 : lane_get(spad_m[r], int'(w));
            nrow = f ? '0 : spad_m[r];
            nrow = lane_put(nrow, int'(w), ref_add(total, psum));
            spad_m[r] = nrow;
            zv = nrow;
        end
    endtask

    // mostly below 8.0, now and then the full range
    function automatic word_t rand_word(int big_pct);
        word_t w;
        w = $urandom;
        if (($urandom % 100) >= big_pct) begin
            w[30:18] = '0;
        end
        return w;
    endfunction

    function automatic vec_t rand_vec(int big_pct);
        vec_t v;
        v = '0;
        for (int l = 0; l < num_lanes; l++) begin
            v = lane_put(v, l, rand_word(big_pct));
        end
        return v;
    endfunction

    // consumer gives a credit back some random time after each result
    always @(posedge in_clk) begin
        #1;
        credit_return = 1'b0;
        if (returns_on && credits_sent < results_seen && ($urandom % 100) < return_pct) begin
            credit_return = 1'b1;
            credits_sent++;
        end
    end

    // checks run in the low phase, where inputs and outputs are stable
    always @(negedge in_clk) begin
        int         applied_ret;
        int         lat;
        vec_t       zexp;
        op_t        eop;
        lane_mask_t emask;
        if (arst_n) begin
            // a pulse driven now only counts at the next edge
            applied_ret = credits_sent - int'(credit_return);
            assert (ready == ((acc_cnt - applied_ret) < result_credits)) else begin
                $display("FAILED %s ready: expected %0b actual %0b",
                         test_name, (acc_cnt - applied_ret) < result_credits, ready);
                err_proto++;
            end
            assert (acc_cnt - applied_ret <= result_credits) else begin
                $display("%0d results outstanding in %s, more than the credits allow",
                         acc_cnt - applied_ret, test_name);
                err_proto++;
            end
            if (result_valid) begin
                results_seen++;
                assert (exp_z.size() != 0) else begin
                    $display("result_valid in %s with no operation in flight", test_name);
                    err_proto++;
                end
                if (exp_z.size() != 0) begin
                    zexp  = exp_z.pop_front();
                    eop   = exp_op.pop_front();
                    emask = exp_mask.pop_front();
                    lat   = cyc - exp_cyc.pop_front();
                    assert (z === zexp) else begin
                        $display("FAILED %s %s: expected %h actual %h",
                                 test_name, eop.name(), zexp, z);
                        err_data++;
                    end
                    assert (lat == 3) else begin
                        $display("FAILED %s latency: expected 3 actual %0d", test_name, lat);
                        err_data++;
                    end
                    for (int l = 0; l < num_lanes; l++) begin
                        if (eop != op_mvmul && !emask[num_lanes-1-l]) begin
                            assert (lane_get(z, l) == '0) else begin
                                $display("FAILED %s masked lane %0d: expected %h actual %h",
                                         test_name, l, 32'h0, lane_get(z, l));
                                err_data++;
                            end
                        end
                    end
                end
            end
            if (valid && ready) begin
                model_op(op, mask, x, y, row, word, first, zexp);
                exp_z.push_back(zexp);
                exp_op.push_back(op);
                exp_mask.push_back(mask);
                exp_cyc.push_back(cyc);
                acc_cnt++;
            end
        end
    end

    task automatic issue(input op_t o, input lane_mask_t m, input vec_t xv, input vec_t yv,
                         input row_addr_t r, input word_sel_t w, input logic f);
        int waited;
        waited = 0;
        while (!ready && waited < wait_limit) begin
            @(posedge in_clk);
            #1;
            waited++;
        end
        if (!ready) begin
            $display("timeout: ready stayed low for %0d cycles in %s", wait_limit, test_name);
            err_timeout++;
        end else begin
            valid = 1'b1;
            op    = o;
            mask  = m;
            x     = xv;
            y     = yv;
            row   = r;
            word  = w;
            first = f;
            @(posedge in_clk);
            #1;
            valid = 1'b0;
        end
    endtask

    // polls in the low phase, then lines up again just after a rising edge
    task automatic wait_idle(input logic credits_too);
        int   waited;
        logic busy;
        waited = 0;
        do begin
            @(negedge in_clk);
            #1;
            waited++;
            busy = exp_z.size() != 0 ||
                   (credits_too && (credits_sent != results_seen || credit_return));
        end while (busy && waited < wait_limit);
        if (busy) begin
            $display("timeout: %s did not drain within %0d cycles", test_name, wait_limit);
            err_timeout++;
        end
        @(posedge in_clk);
        #1;
    endtask

    initial begin
        logic started [2];
        int   n;
        int   rsel;
        op_t  o;
        void'($urandom(32'hb5cf_cea9));
        arst_n = 1'b0;
        valid  = 1'b0;
        op     = op_nop;
        mask   = '0;
        x      = '0;
        y      = '0;
        row    = '0;
        word   = '0;
        first  = 1'b0;
        repeat (4) @(posedge in_clk);
        #1;
        arst_n = 1'b1;

        // a fresh DUT accepts exactly its credit count with nothing returned
        assert (!result_valid && ready) else begin
            $display("FAILED reset result_valid and ready: expected 0 1 actual %0b %0b",
                     result_valid, ready);
            err_proto++;
        end
        n = 0;
        while (ready && n <= result_credits) begin
            issue(op_vadd, 4'hf, rand_vec(0), rand_vec(0), '0, '0, 1'b0);
            n++;
        end
        assert (n == result_credits) else begin
            $display("FAILED reset accepted: expected %0d actual %0d", result_credits, n);
            err_data++;
        end
        wait_idle(1'b0);
        returns_on = 1'b1;
        wait_idle(1'b1);

        test_name = "elementwise";
        for (n = 0; n < 40; n++) begin
            o = op_t'(3'(1 + $urandom % 4));
            issue(o, 4'hf, rand_vec(6), rand_vec(6), '0, '0, 1'b0);
        end
        wait_idle(1'b1);

        test_name = "masking";
        for (n = 0; n < 40; n++) begin
            o = op_t'(3'(1 + $urandom % 4));
            issue(o, lane_mask_t'($urandom), rand_vec(6), rand_vec(6), '0, '0, 1'b0);
        end
        wait_idle(1'b1);

        // rows 2 and 5 in the order 2 5 2 2 5 5 for every word
        test_name  = "mvmul";
        started[0] = 1'b0;
        started[1] = 1'b0;
        for (int w = 0; w < num_lanes; w++) begin
            for (int k = 0; k < 6; k++) begin
                rsel = (k == 1 || k >= 4) ? 1 : 0;
                issue(op_mvmul, 4'hf, rand_vec(0), rand_vec(0), (rsel != 0) ? 4'd5 : 4'd2,
                      word_sel_t'(w), !started[rsel]);
                started[rsel] = 1'b1;
            end
        end
        wait_idle(1'b1);

        test_name  = "credits";
        return_pct = 20;
        for (n = 0; n < 60; n++) begin
            o = op_t'(3'(1 + $urandom % 5));
            rsel = $urandom % 2;
            issue(o, lane_mask_t'($urandom), rand_vec(0), rand_vec(0),
                  (rsel != 0) ? 4'd5 : 4'd2, word_sel_t'($urandom), 1'b0);
            if ($urandom % 4 == 0) begin
                @(posedge in_clk);
                #1;
            end
        end
        wait_idle(1'b1);

        assert (acc_cnt == results_seen) else begin
            $display("%0d operations accepted but %0d results seen", acc_cnt, results_seen);
            err_proto++;
        end
        $display("errors: data %0d, protocol %0d, timeout %0d", err_data, err_proto, err_timeout);
        if (err_data + err_proto + err_timeout == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
